// ==== sim.f ====
source/tcdm_pkg.sv
source/rr_arbiter.sv
source/full_duplex_xbar.sv
source/variable_latency_interconnect.sv
source/tcdm_bank.sv
source/tcdm_cluster_top.sv
testbench/tb_tcdm_cluster.sv

// ==== Bender.yml ====
package:
  name: tcdm_cluster

sources:
  - files:
      - source/tcdm_pkg.sv
      - source/rr_arbiter.sv
      - source/full_duplex_xbar.sv
      - source/variable_latency_interconnect.sv
      - source/tcdm_bank.sv
      - source/tcdm_cluster_top.sv
  - target: test
    files:
      - testbench/tb_tcdm_cluster.sv

// ==== testbench/tb_tcdm_cluster.sv ====
`timescale 1ns/1ps

module tb_tcdm_cluster;

  localparam int NumIn        = tcdm_pkg::DefNumIn;
  localparam int NumOut       = tcdm_pkg::DefNumOut;
  localparam int DataWidth    = tcdm_pkg::DefDataWidth;
  localparam int AddrMemWidth = tcdm_pkg::DefAddrMemWidth;
  localparam int BeWidth      = DataWidth / 8;
  localparam int ByteShift    = $clog2(BeWidth);
  localparam int NumWords     = NumOut << AddrMemWidth;  // Words in the whole cluster
  localparam int MaxWait      = 64;                      // Per-handshake limit in cycles
  localparam int NumRandom    = 300;
  // Cycle budget of each test in run order
  localparam int BudgetCycles   = 20 + 100 + 100 + 50 + 50 + NumRandom * 15;
  localparam int WatchdogCycles = 4 * BudgetCycles;

  logic                           clk_i = 1'b0;
  logic                           arst_n_i;
  logic [NumIn-1:0]               req_valid_i;
  logic [NumIn-1:0]               req_ready_o;
  logic [NumIn-1:0][31:0]         req_addr_i;
  logic [NumIn-1:0]               req_wen_i;
  logic [NumIn-1:0][DataWidth-1:0] req_wdata_i;
  logic [NumIn-1:0][BeWidth-1:0]  req_be_i;
  logic [NumIn-1:0]               resp_valid_o;
  logic [NumIn-1:0][DataWidth-1:0] resp_rdata_o;
  logic [NumIn-1:0]               resp_ready_i;

  logic [DataWidth-1:0] mem_model [int unsigned];  // Keyed by word address
  int errors       = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  always #10 clk_i = ~clk_i;  // 20 ns period

  tcdm_cluster_top #(
    .NumIn        (NumIn),
    .NumOut       (NumOut),
    .DataWidth    (DataWidth),
    .AddrMemWidth (AddrMemWidth)
  ) u_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_wen_i    (req_wen_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_ready_i (resp_ready_i)
  );

  // Bank in the low bits and row above
  function automatic int unsigned word_of(input int bank, input int row);
    return row * NumOut + bank;
  endfunction

  // Enabled bytes take new data and the rest keep old data
  function automatic void model_write(input int unsigned w, input logic [DataWidth-1:0] data,
                                      input logic [BeWidth-1:0] be);
    logic [DataWidth-1:0] word;
    word = mem_model.exists(w) ? mem_model[w] : '0;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) word[b*8 +: 8] = data[b*8 +: 8];
    end
    mem_model[w] = word;
  endfunction

  function automatic void close_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - err_start);
    end
  endfunction

  // One request and its response on one initiator port
  task automatic issue(input int ini, input logic wen, input int unsigned w,
                       input logic [DataWidth-1:0] wdata, input logic [BeWidth-1:0] be,
                       input int stall, output logic [DataWidth-1:0] rdata,
                       output int acc, output int lat);
    logic [DataWidth-1:0] held;
    acc   = 0;
    lat   = 1;
    rdata = 'x;
    @(negedge clk_i);
    req_valid_i[ini]  = 1'b1;
    req_addr_i[ini]   = w << ByteShift;
    req_wen_i[ini]    = wen;
    req_wdata_i[ini]  = wdata;
    req_be_i[ini]     = be;
    resp_ready_i[ini] = (stall == 0);
    #1;
    while (!req_ready_o[ini]) begin  // Valid held until accepted
      if (++acc > MaxWait) begin
        $display("Initiator %0d: request to word %h never accepted", ini, w);
        errors++;
        @(negedge clk_i);
        req_valid_i[ini] = 1'b0;
        return;
      end
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);  // Handshake on the edge just passed
    req_valid_i[ini] = 1'b0;
    #1;
    while (!resp_valid_o[ini]) begin
      if (++lat > MaxWait) begin
        $display("Initiator %0d: no response for word %h", ini, w);
        errors++;
        return;
      end
      @(negedge clk_i);
      #1;
    end
    held = resp_rdata_o[ini];
    for (int s = 1; s <= stall; s++) begin
      @(negedge clk_i);
      if (s == stall) resp_ready_i[ini] = 1'b1;  // Release after the stall
      #1;
      if (resp_valid_o[ini] !== 1'b1 || resp_rdata_o[ini] !== held) begin
        $display("FAILED resp_rdata_o[%0d] under stall: expected %h, got %h (valid %h)",
                 ini, held, resp_rdata_o[ini], resp_valid_o[ini]);
        errors++;
      end
    end
    rdata = resp_rdata_o[ini];
  endtask

  task automatic reset_and_idle();
    int e0;
    e0 = errors;
    for (int c = 0; c < 13; c++) begin
      @(negedge clk_i);
      if (c == 2) arst_n_i = 1'b1;  // Three cycles in reset
      #1;
      if (resp_valid_o !== '0) begin
        $display("FAILED resp_valid_o: expected %h, got %h", {NumIn{1'b0}}, resp_valid_o);
        errors++;
      end
    end
    close_test("reset", e0);
  endtask

  task automatic write_read_banks();
    logic [DataWidth-1:0] rd, data;
    int acc, lat, e0;
    e0 = errors;
    for (int pass = 0; pass < 2; pass++) begin  // Writes, then reads
      for (int b = 0; b < NumOut; b++) begin
        data = $urandom();
        if (pass == 0) model_write(word_of(b, 7 + b), data, '1);
        issue(0, pass == 0, word_of(b, 7 + b), data, '1, 0, rd, acc, lat);
        if (lat != 1) begin
          $display("Bank %0d answered after %0d cycles instead of 1", b, lat);
          errors++;
        end
        if (pass == 1 && rd !== mem_model[word_of(b, 7 + b)]) begin
          $display("FAILED resp_rdata_o[0]: expected %h, got %h",
                   mem_model[word_of(b, 7 + b)], rd);
          errors++;
        end
      end
    end
    close_test("bank_rw", e0);
  endtask

  task automatic merge_byte_enables();
    logic [BeWidth-1:0] bes [5] = '{4'b0101, 4'b1000, 4'b0110, 4'b0011, 4'b0000};
    logic [DataWidth-1:0] rd, data;
    int acc, lat, e0;
    e0 = errors;
    model_write(word_of(1, 9), 32'h1122_3344, '1);
    issue(2, 1'b1, word_of(1, 9), 32'h1122_3344, '1, 0, rd, acc, lat);
    foreach (bes[k]) begin
      data = $urandom();
      model_write(word_of(1, 9), data, bes[k]);
      issue(2, 1'b1, word_of(1, 9), data, bes[k], 0, rd, acc, lat);
      issue(2, 1'b0, word_of(1, 9), '0, '0, 0, rd, acc, lat);
      if (rd !== mem_model[word_of(1, 9)]) begin
        $display("FAILED resp_rdata_o[2]: expected %h, got %h", mem_model[word_of(1, 9)], rd);
        errors++;
      end
    end
    close_test("byte_enable", e0);
  endtask

  task automatic contend_one_bank();
    logic [DataWidth-1:0] rd [NumIn];
    int acc [NumIn];
    int lat [NumIn];
    int first, e0;
    e0 = errors;
    first = 1;  // Bank 3 last granted initiator 0
    model_write(word_of(3, 20), 32'hcafe_0003, '1);
    issue(0, 1'b1, word_of(3, 20), 32'hcafe_0003, '1, 0, rd[0], acc[0], lat[0]);
    fork  // All four hit bank 3 at once
      issue(0, 1'b0, word_of(3, 20), '0, '0, 0, rd[0], acc[0], lat[0]);
      issue(1, 1'b0, word_of(3, 20), '0, '0, 0, rd[1], acc[1], lat[1]);
      issue(2, 1'b0, word_of(3, 20), '0, '0, 0, rd[2], acc[2], lat[2]);
      issue(3, 1'b0, word_of(3, 20), '0, '0, 0, rd[3], acc[3], lat[3]);
    join
    for (int k = 0; k < NumIn; k++) begin
      if (acc[(first + k) % NumIn] != k) begin  // Round-robin order from the pointer
        $display("Initiator %0d waited %0d grants, expected %0d",
                 (first + k) % NumIn, acc[(first + k) % NumIn], k);
        errors++;
      end
      if (rd[k] !== mem_model[word_of(3, 20)]) begin
        $display("FAILED resp_rdata_o[%0d]: expected %h, got %h",
                 k, mem_model[word_of(3, 20)], rd[k]);
        errors++;
      end
    end
    close_test("fairness", e0);
  endtask

  task automatic stall_response();
    logic [DataWidth-1:0] rd1, rd3;
    int acc1, acc3, lat1, lat3, e0;
    e0 = errors;
    model_write(word_of(2, 30), 32'h0bad_f00d, '1);
    model_write(word_of(2, 31), 32'h600d_cafe, '1);
    issue(0, 1'b1, word_of(2, 30), 32'h0bad_f00d, '1, 0, rd1, acc1, lat1);
    issue(0, 1'b1, word_of(2, 31), 32'h600d_cafe, '1, 0, rd1, acc1, lat1);
    fork
      issue(1, 1'b0, word_of(2, 30), '0, '0, 8, rd1, acc1, lat1);
      begin
        @(negedge clk_i);  // One cycle behind initiator 1
        issue(3, 1'b0, word_of(2, 31), '0, '0, 0, rd3, acc3, lat3);
      end
    join
    if (acc3 < 8) begin
      $display("Initiator 3 was accepted after %0d cycles while bank 2 stalled", acc3);
      errors++;
    end
    if (rd1 !== mem_model[word_of(2, 30)]) begin
      $display("FAILED resp_rdata_o[1]: expected %h, got %h", mem_model[word_of(2, 30)], rd1);
      errors++;
    end
    if (rd3 !== mem_model[word_of(2, 31)]) begin
      $display("FAILED resp_rdata_o[3]: expected %h, got %h", mem_model[word_of(2, 31)], rd3);
      errors++;
    end
    close_test("backpressure", e0);
  endtask

  // Each initiator works in its own quarter of the words
  task automatic random_stream(input int ini, input int count);
    logic [DataWidth-1:0] wdata, exp, rd;
    logic [BeWidth-1:0]   be;
    logic                 wen;
    int unsigned          w;
    int                   acc, lat;
    for (int n = 0; n < count; n++) begin
      w     = ini * (NumWords / NumIn) + $urandom() % (NumWords / NumIn);
      wen   = $urandom() % 2;
      wdata = $urandom();
      be    = $urandom();
      if (!mem_model.exists(w)) begin
        wen = 1'b1;  // First touch writes the full word
        be  = '1;
      end
      exp = mem_model[w];
      if (wen) model_write(w, wdata, be);
      issue(ini, wen, w, wdata, be, $urandom() % 4, rd, acc, lat);
      if (!wen && rd !== exp) begin
        $display("FAILED resp_rdata_o[%0d]: expected %h, got %h", ini, exp, rd);
        errors++;
      end
    end
  endtask

  task automatic random_traffic();
    int e0;
    e0 = errors;
    fork
      random_stream(0, NumRandom / NumIn);
      random_stream(1, NumRandom / NumIn);
      random_stream(2, NumRandom / NumIn);
      random_stream(3, NumRandom / NumIn);
    join
    for (int c = 0; c < 5; c++) begin  // No response without a request
      @(negedge clk_i);
      #1;
      if (resp_valid_o !== '0) begin
        $display("FAILED resp_valid_o: expected %h, got %h", {NumIn{1'b0}}, resp_valid_o);
        errors++;
      end
    end
    close_test("random", e0);
  endtask

  initial begin
    void'($urandom(32'h665cdf3e));
    arst_n_i     = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '1;
    reset_and_idle();
    write_read_banks();
    merge_byte_enables();
    contend_one_bank();
    stall_response();
    random_traffic();
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Run timed out after %0d cycles", WatchdogCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_tcdm_cluster

// ==== source/tcdm_cluster_top.sv ====
`timescale 1ns/1ps

module tcdm_cluster_top #(
  parameter int unsigned NumIn        = tcdm_pkg::DefNumIn,
  parameter int unsigned NumOut       = tcdm_pkg::DefNumOut,
  parameter int unsigned DataWidth    = tcdm_pkg::DefDataWidth,
  parameter int unsigned AddrMemWidth = tcdm_pkg::DefAddrMemWidth,
  localparam int unsigned AddrWidth   = 32,
  localparam int unsigned BeWidth     = DataWidth / 8
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [NumIn-1:0]                 req_valid_i,
  output logic [NumIn-1:0]                 req_ready_o,
  input  logic [NumIn-1:0][AddrWidth-1:0]  req_addr_i,
  input  logic [NumIn-1:0]                 req_wen_i,   // 1 for write
  input  logic [NumIn-1:0][DataWidth-1:0]  req_wdata_i,
  input  logic [NumIn-1:0][BeWidth-1:0]    req_be_i,
  output logic [NumIn-1:0]                 resp_valid_o,
  output logic [NumIn-1:0][DataWidth-1:0]  resp_rdata_o,
  input  logic [NumIn-1:0]                 resp_ready_i
);

  localparam int unsigned IniSelWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  // Interconnect to bank wires
  logic [NumOut-1:0]                   bank_req_valid;
  logic [NumOut-1:0]                   bank_req_ready;
  logic [NumOut-1:0][IniSelWidth-1:0]  bank_req_ini;
  logic [NumOut-1:0][AddrMemWidth-1:0] bank_req_row;
  logic [NumOut-1:0]                   bank_req_wen;
  logic [NumOut-1:0][DataWidth-1:0]    bank_req_wdata;
  logic [NumOut-1:0][BeWidth-1:0]      bank_req_be;
  logic [NumOut-1:0]                   bank_resp_valid;
  logic [NumOut-1:0]                   bank_resp_ready;
  logic [NumOut-1:0][IniSelWidth-1:0]  bank_resp_ini;
  logic [NumOut-1:0][DataWidth-1:0]    bank_resp_rdata;

  variable_latency_interconnect #(
    .NumIn        (NumIn),
    .NumOut       (NumOut),
    .AddrWidth    (AddrWidth),
    .DataWidth    (DataWidth),
    .BeWidth      (BeWidth),
    .AddrMemWidth (AddrMemWidth)
  ) u_interco (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_wen_i       (req_wen_i),
    .req_wdata_i     (req_wdata_i),
    .req_be_i        (req_be_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_ready_i    (resp_ready_i),
    .req_valid_o     (bank_req_valid),
    .req_ini_addr_o  (bank_req_ini),
    .req_tgt_addr_o  (bank_req_row),
    .req_wen_o       (bank_req_wen),
    .req_wdata_o     (bank_req_wdata),
    .req_be_o        (bank_req_be),
    .req_ready_i     (bank_req_ready),
    .resp_valid_i    (bank_resp_valid),
    .resp_ini_addr_i (bank_resp_ini),
    .resp_rdata_i    (bank_resp_rdata),
    .resp_ready_o    (bank_resp_ready)
  );

  // Bank array, one bank per word offset
  for (genvar b = 0; b < NumOut; b++) begin : gen_banks
    tcdm_bank #(
      .NumIn        (NumIn),
      .DataWidth    (DataWidth),
      .AddrMemWidth (AddrMemWidth)
    ) u_bank (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_valid_i  (bank_req_valid[b]),
      .req_ini_i    (bank_req_ini[b]),
      .req_row_i    (bank_req_row[b]),
      .req_wen_i    (bank_req_wen[b]),
      .req_wdata_i  (bank_req_wdata[b]),
      .req_be_i     (bank_req_be[b]),
      .req_ready_o  (bank_req_ready[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_ini_o   (bank_resp_ini[b]),
      .resp_rdata_o (bank_resp_rdata[b]),
      .resp_ready_i (bank_resp_ready[b])
    );
  end

endmodule : tcdm_cluster_top

// ==== source/tcdm_bank.sv ====
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned NumIn        = 4,
  parameter int unsigned DataWidth    = 32,
  parameter int unsigned AddrMemWidth = 6,
  localparam int unsigned BeWidth     = DataWidth / 8,
  localparam int unsigned IniSelWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  logic [IniSelWidth-1:0]  req_ini_i,   // Tag, echoed in the response
  input  logic [AddrMemWidth-1:0] req_row_i,
  input  logic                    req_wen_i,   // Raw opcode bit
  input  logic [DataWidth-1:0]    req_wdata_i,
  input  logic [BeWidth-1:0]      req_be_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output logic [IniSelWidth-1:0]  resp_ini_o,
  output logic [DataWidth-1:0]    resp_rdata_o,
  input  logic                    resp_ready_i
);

  localparam int unsigned NumWords = 2 ** AddrMemWidth;

  tcdm_pkg::mem_op_e     req_op;
  logic                  req_hs;                // Request accepted this cycle
  logic [DataWidth-1:0]  mem_q [NumWords];      // Storage array
  logic                  resp_valid_q;
  logic [IniSelWidth-1:0] resp_ini_q;
  logic [DataWidth-1:0]  resp_rdata_q;

  assign req_op = tcdm_pkg::mem_op_e'(req_wen_i);

  // Free slot, or slot drained in the same cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_hs      = req_valid_i && req_ready_o;

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (req_hs && req_op == tcdm_pkg::OP_WRITE) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (req_be_i[b]) mem_q[req_row_i][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
      end
    end
  end

  // Response flag
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_hs) begin
      resp_valid_q <= 1'b1;  // New response replaces a drained one
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Response payload, written only on acceptance
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      resp_ini_q   <= req_ini_i;
      resp_rdata_q <= (req_op == tcdm_pkg::OP_READ) ? mem_q[req_row_i] : '0; // Old word
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = resp_ini_q;
  assign resp_rdata_o = resp_rdata_q;

  // Stalled response keeps its tag and data
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_rdata_o) && $stable(resp_ini_o))
    else $error("[tcdm_bank] stalled response changed");

  // Waiting request stays valid through the crossbar
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i)
    else $error("[tcdm_bank] pending request withdrawn");

endmodule : tcdm_bank

// ==== source/variable_latency_interconnect.sv ====
`timescale 1ns/1ps

module variable_latency_interconnect #(
  parameter int unsigned NumIn        = 4,
  parameter int unsigned NumOut       = 4,  // Power of two
  parameter int unsigned AddrWidth    = 32,
  parameter int unsigned DataWidth    = 32,
  parameter int unsigned BeWidth      = DataWidth / 8,
  parameter int unsigned AddrMemWidth = 6,
  localparam int unsigned IniSelWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  // Initiator side
  input  logic [NumIn-1:0]                     req_valid_i,
  input  logic [NumIn-1:0][AddrWidth-1:0]      req_addr_i,      // Byte address
  input  logic [NumIn-1:0]                     req_wen_i,
  input  logic [NumIn-1:0][DataWidth-1:0]      req_wdata_i,
  input  logic [NumIn-1:0][BeWidth-1:0]        req_be_i,
  output logic [NumIn-1:0]                     req_ready_o,
  output logic [NumIn-1:0]                     resp_valid_o,
  output logic [NumIn-1:0][DataWidth-1:0]      resp_rdata_o,
  input  logic [NumIn-1:0]                     resp_ready_i,
  // Bank side
  output logic [NumOut-1:0]                    req_valid_o,
  output logic [NumOut-1:0][IniSelWidth-1:0]   req_ini_addr_o,  // Initiator tag
  output logic [NumOut-1:0][AddrMemWidth-1:0]  req_tgt_addr_o,  // Row inside the bank
  output logic [NumOut-1:0]                    req_wen_o,       // Opcode bit
  output logic [NumOut-1:0][DataWidth-1:0]     req_wdata_o,
  output logic [NumOut-1:0][BeWidth-1:0]       req_be_o,
  input  logic [NumOut-1:0]                    req_ready_i,
  input  logic [NumOut-1:0]                    resp_valid_i,
  input  logic [NumOut-1:0][IniSelWidth-1:0]   resp_ini_addr_i,
  input  logic [NumOut-1:0][DataWidth-1:0]     resp_rdata_i,
  output logic [NumOut-1:0]                    resp_ready_o
);

  localparam int unsigned ByteOffWidth    = $clog2(BeWidth);
  localparam int unsigned NumOutLog2      = $clog2(NumOut);
  localparam int unsigned TgtSelWidth     = (NumOut > 1) ? NumOutLog2 : 1;
  // Opcode, byte enables, row, data
  localparam int unsigned IniAggDataWidth = 1 + BeWidth + AddrMemWidth + DataWidth;

  tcdm_pkg::mem_op_e                      op_in [NumIn];
  logic [NumIn-1:0][TgtSelWidth-1:0]      tgt_sel;      // Bank index per initiator
  logic [NumIn-1:0][AddrMemWidth-1:0]     row_sel;
  logic [NumIn-1:0][IniAggDataWidth-1:0]  data_agg_in;
  logic [NumOut-1:0][IniAggDataWidth-1:0] data_agg_out;

  for (genvar j = 0; j < NumIn; j++) begin : gen_inputs
    assign op_in[j]   = req_wen_i[j] ? tcdm_pkg::OP_WRITE : tcdm_pkg::OP_READ;
    // Word interleaving, bank bits right above the byte offset
    assign tgt_sel[j] = TgtSelWidth'((req_addr_i[j] >> ByteOffWidth) & (NumOut - 1));
    assign row_sel[j] = AddrMemWidth'(req_addr_i[j] >> (ByteOffWidth + NumOutLog2));
    assign data_agg_in[j] = {op_in[j], req_be_i[j], row_sel[j], req_wdata_i[j]};
  end

  // Unpack at each bank
  for (genvar k = 0; k < NumOut; k++) begin : gen_outputs
    assign {req_wen_o[k], req_be_o[k], req_tgt_addr_o[k], req_wdata_o[k]} = data_agg_out[k];
  end

  full_duplex_xbar #(
    .NumIn         (NumIn),
    .NumOut        (NumOut),
    .ReqDataWidth  (IniAggDataWidth),
    .RespDataWidth (DataWidth)
  ) u_xbar (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_tgt_i    (tgt_sel),
    .req_wdata_i  (data_agg_in),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_ready_i (resp_ready_i),
    .req_valid_o  (req_valid_o),
    .req_ini_o    (req_ini_addr_o),
    .req_wdata_o  (data_agg_out),
    .req_ready_i  (req_ready_i),
    .resp_valid_i (resp_valid_i),
    .resp_ini_i   (resp_ini_addr_i),
    .resp_rdata_i (resp_rdata_i),
    .resp_ready_o (resp_ready_o)
  );

  // Elaboration checks
  if (ByteOffWidth + NumOutLog2 + AddrMemWidth > AddrWidth)
    $fatal(1, "[variable_latency_interconnect] address too narrow for banks and rows");
  if ((1 << NumOutLog2) != NumOut)
    $fatal(1, "[variable_latency_interconnect] NumOut must be a power of two");

endmodule : variable_latency_interconnect

// ==== source/full_duplex_xbar.sv ====
`timescale 1ns/1ps

module full_duplex_xbar #(
  parameter int unsigned NumIn         = 4,
  parameter int unsigned NumOut        = 4,
  parameter int unsigned ReqDataWidth  = 32,
  parameter int unsigned RespDataWidth = 32,
  localparam int unsigned IniSelWidth  = (NumIn > 1) ? $clog2(NumIn) : 1,
  localparam int unsigned TgtSelWidth  = (NumOut > 1) ? $clog2(NumOut) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Initiator side
  input  logic [NumIn-1:0]                      req_valid_i,
  input  logic [NumIn-1:0][TgtSelWidth-1:0]     req_tgt_i,    // Target select
  input  logic [NumIn-1:0][ReqDataWidth-1:0]    req_wdata_i,  // Packed payload
  output logic [NumIn-1:0]                      req_ready_o,
  output logic [NumIn-1:0]                      resp_valid_o,
  output logic [NumIn-1:0][RespDataWidth-1:0]   resp_rdata_o,
  input  logic [NumIn-1:0]                      resp_ready_i,
  // Target side
  output logic [NumOut-1:0]                     req_valid_o,
  output logic [NumOut-1:0][IniSelWidth-1:0]    req_ini_o,    // Tag of the granted initiator
  output logic [NumOut-1:0][ReqDataWidth-1:0]   req_wdata_o,
  input  logic [NumOut-1:0]                     req_ready_i,
  input  logic [NumOut-1:0]                     resp_valid_i,
  input  logic [NumOut-1:0][IniSelWidth-1:0]    resp_ini_i,   // Returned tag
  input  logic [NumOut-1:0][RespDataWidth-1:0]  resp_rdata_i,
  output logic [NumOut-1:0]                     resp_ready_o
);

  logic [NumOut-1:0][NumIn-1:0]    req_mat;    // Request per target, per initiator
  logic [NumOut-1:0][NumIn-1:0]    req_gnt;
  logic [NumIn-1:0][NumOut-1:0]    req_gnt_t;  // Same grants seen per initiator
  logic [NumIn-1:0][NumOut-1:0]    resp_mat;   // Response per initiator, per target
  logic [NumIn-1:0][NumOut-1:0]    resp_gnt;
  logic [NumOut-1:0][NumIn-1:0]    resp_gnt_t;
  logic [NumIn-1:0][TgtSelWidth-1:0] resp_sel; // Winning target per initiator

  // Request crossbar
  for (genvar t = 0; t < NumOut; t++) begin : gen_req_tgt
    for (genvar i = 0; i < NumIn; i++) begin : gen_req_ini
      assign req_mat[t][i]   = req_valid_i[i] && (req_tgt_i[i] == TgtSelWidth'(t));
      assign req_gnt_t[i][t] = req_gnt[t][i];
    end

    rr_arbiter #(
      .NumReq (NumIn)
    ) u_req_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (req_mat[t]),
      .gnt_i    (req_ready_i[t]),
      .gnt_o    (req_gnt[t]),
      .valid_o  (req_valid_o[t]),
      .idx_o    (req_ini_o[t])
    );

    assign req_wdata_o[t] = req_wdata_i[req_ini_o[t]]; // Payload of the winner
  end

  // Ready back to an initiator from whichever target granted it
  for (genvar i = 0; i < NumIn; i++) begin : gen_req_rdy
    assign req_ready_o[i] = |req_gnt_t[i];
  end

  // Response crossbar, mirror image keyed by the tag
  for (genvar i = 0; i < NumIn; i++) begin : gen_resp_ini
    for (genvar t = 0; t < NumOut; t++) begin : gen_resp_tgt
      assign resp_mat[i][t]   = resp_valid_i[t] && (resp_ini_i[t] == IniSelWidth'(i));
      assign resp_gnt_t[t][i] = resp_gnt[i][t];
    end

    rr_arbiter #(
      .NumReq (NumOut)
    ) u_resp_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (resp_mat[i]),
      .gnt_i    (resp_ready_i[i]),
      .gnt_o    (resp_gnt[i]),
      .valid_o  (resp_valid_o[i]),
      .idx_o    (resp_sel[i])
    );

    assign resp_rdata_o[i] = resp_rdata_i[resp_sel[i]];
  end

  for (genvar t = 0; t < NumOut; t++) begin : gen_resp_rdy
    assign resp_ready_o[t] = |resp_gnt_t[t]; // Bank response taken
  end

  for (genvar i = 0; i < NumIn; i++) begin : gen_asserts
    // Two targets must never take the same request
    a_single_tgt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(req_gnt_t[i]))
      else $error("[full_duplex_xbar] initiator %0d granted twice", i);

    // Initiator holds valid and payload until accepted
    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i[i] && !req_ready_o[i] |=>
        req_valid_i[i] && $stable(req_tgt_i[i]) && $stable(req_wdata_i[i]))
      else $error("[full_duplex_xbar] request %0d dropped or changed", i);
  end

endmodule : full_duplex_xbar

// ==== source/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumReq   = 4,
  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [NumReq-1:0]   req_i,   // Requests from the inputs
  input  logic                gnt_i,   // Downstream ready
  output logic [NumReq-1:0]   gnt_o,   // One-hot grant back to the inputs
  output logic                valid_o, // Some input requests
  output logic [IdxWidth-1:0] idx_o    // Index of the winner
);

  logic [IdxWidth-1:0] ptr_q;   // Highest priority position
  logic [IdxWidth-1:0] win_idx; // First requester at or after ptr_q
  logic                found;

  // Rotating search starting at the priority pointer
  always_comb begin
    int unsigned pos;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      pos = (int'(ptr_q) + k) % NumReq;
      if (!found && req_i[pos]) begin
        found   = 1'b1;
        win_idx = IdxWidth'(pos);
      end
    end
  end

  assign valid_o = found;
  assign idx_o   = win_idx;

  // Grant only once downstream takes it
  always_comb begin
    gnt_o = '0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      gnt_o[k] = found && gnt_i && (win_idx == IdxWidth'(k));
    end
  end

  // Pointer moves one past the winner on an accepted grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (found && gnt_i) begin
      if (win_idx == IdxWidth'(NumReq - 1)) ptr_q <= '0; // Wrap
      else                                  ptr_q <= win_idx + 1'b1;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o))
    else $error("[rr_arbiter] more than one grant");

  // A grant never lands on an idle input
  a_gnt_to_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o & ~req_i) == '0)
    else $error("[rr_arbiter] grant without request");

endmodule : rr_arbiter

// ==== source/tcdm_pkg.sv ====
package tcdm_pkg;

  // Memory access opcode carried in the request payload
  typedef enum logic {
    OP_READ  = 1'b0, // Word read, data returned
    OP_WRITE = 1'b1  // Byte-enabled write, zero returned
  } mem_op_e;

  // Default cluster sizes
  // Initiator ports
  parameter int DefNumIn = 4;
  // Banks, power of two for the word interleaving
  parameter int DefNumOut = 4;

  // Word width in bits
  parameter int DefDataWidth = 32;

  // Row address bits inside one bank, 64 words per bank
  parameter int DefAddrMemWidth = 6;

endpackage : tcdm_pkg
